/* design/stream_pkg.sv */
// shared widths, lane ratio and enums for the stream transformer; import where needed.
`default_nettype none

package stream_pkg;

    // ########################################################################
    // widths and ratios
    // ########################################################################

    localparam int NARROW_W   = 32;                // stream word.
    localparam int WIDE_W     = 128;               // internal beat.
    localparam int RATIO      = WIDE_W / NARROW_W; // words per beat.
    localparam int CNT_W      = $clog2(RATIO);     // lane counter width.
    localparam int LANE_BYTES = NARROW_W / 8;

    // ########################################################################
    // enums
    // ########################################################################

    // operation carried in bits [1:0] of the header word
    typedef enum logic [1:0] {
        OP_PASS      = 2'b00,  // unchanged.
        OP_INVERT    = 2'b01,  // every bit flipped.
        OP_LANE_REV  = 2'b10,  // lane 3 first.
        OP_BYTE_SWAP = 2'b11   // bytes reversed per lane.
    } opcode_e;

    typedef enum logic {
        ST_HEADER  = 1'b0,
        ST_PAYLOAD = 1'b1
    } dec_state_e;

endpackage

`default_nettype wire

/* design/header_decoder.sv */
// front stage of the transformer; drops the header word and tags each payload word with its opcode.
`default_nettype none
`timescale 1ns/1ps

module header_decoder (
    input  logic                          clk_i,
    input  logic                          rst_i,
    // input stream
    input  logic                          s_valid_i,
    output logic                          s_ready_o,
    input  logic [stream_pkg::NARROW_W-1:0] s_data_i,
    input  logic                          s_last_i,
    // tagged payload stream
    output logic                          m_valid_o,
    input  logic                          m_ready_i,
    output logic [stream_pkg::NARROW_W-1:0] m_data_o,
    output stream_pkg::opcode_e           m_op_o,
    output logic                          m_last_o
);

    import stream_pkg::*;

    dec_state_e state_q;
    opcode_e    op_q;
    logic       s_handshake;

    assign s_handshake = s_valid_i & s_ready_o;

    // headers are always taken; payload follows the downstream ready.
    assign s_ready_o = (state_q == ST_HEADER) ? 1'b1 : m_ready_i;
    assign m_valid_o = (state_q == ST_PAYLOAD) & s_valid_i;
    assign m_data_o  = s_data_i;
    assign m_op_o    = op_q;
    assign m_last_o  = s_last_i;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= ST_HEADER;
        end else if (s_handshake) begin
            case (state_q)
                ST_HEADER:  state_q <= ST_PAYLOAD;
                ST_PAYLOAD: if (s_last_i) state_q <= ST_HEADER;
                default:    state_q <= ST_HEADER;
            endcase
        end
    end

    // upper header bits are ignored.
    always_ff @(posedge clk_i) begin
        if (s_handshake && (state_q == ST_HEADER)) begin
            op_q <= opcode_e'(s_data_i[1:0]);
        end
    end

    // ########################################################################
    // checks
    // ########################################################################

    // a packet always has at least one payload group after its header
    a_header_not_last : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (s_handshake && (state_q == ST_HEADER)) |-> !s_last_i
    ) else $error("header word accepted with last set");

endmodule

`default_nettype wire

/* design/axis_upsizer.sv */
// narrow-to-wide stage; gathers four tagged words into one 128-bit beat, word 0 in lane 0.
`default_nettype none
`timescale 1ns/1ps

module axis_upsizer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            s_valid_i,
    output logic                            s_ready_o,
    input  logic [stream_pkg::NARROW_W-1:0] s_data_i,
    input  stream_pkg::opcode_e             s_op_i,
    input  logic                            s_last_i,
    output logic                            m_valid_o,
    input  logic                            m_ready_i,
    output logic [stream_pkg::WIDE_W-1:0]   m_data_o,
    output stream_pkg::opcode_e             m_op_o,
    output logic                            m_last_o
);

    import stream_pkg::*;

    logic [CNT_W-1:0]                cnt_q;
    logic                            cnt_done;
    logic                            valid_q;
    logic                            last_q;
    opcode_e                         op_q;
    logic [RATIO-1:0][NARROW_W-1:0]  beat_q;
    logic                            s_handshake;
    logic                            m_handshake;

    assign s_handshake = s_valid_i & s_ready_o;
    assign m_handshake = valid_q & m_ready_i;
    assign cnt_done    = (cnt_q == CNT_W'(RATIO - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (s_handshake) begin
            cnt_q <= cnt_done ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (m_handshake) begin
            valid_q <= 1'b0;
        end else if (s_handshake & cnt_done) begin
            valid_q <= 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_handshake) begin
            beat_q[cnt_q] <= s_data_i;
        end
        if (s_handshake && (cnt_q == '0)) begin
            op_q <= s_op_i;  // one opcode per beat.
        end
        if (s_handshake & cnt_done) begin
            last_q <= s_last_i;
        end
    end

    assign s_ready_o = ~valid_q;  // stalls while the beat waits.
    assign m_valid_o = valid_q;
    assign m_data_o  = beat_q;
    assign m_op_o    = op_q;
    assign m_last_o  = last_q;

    a_last_on_final_lane : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (s_handshake && s_last_i) |-> cnt_done
    ) else $error("last seen before a group of four completed");

endmodule

`default_nettype wire

/* design/lane_executor.sv */
// execute stage; applies the beat's opcode to the 128-bit data and registers the result.
`default_nettype none
`timescale 1ns/1ps

module lane_executor (
    input  logic                          clk_i,
    input  logic                          rst_i,
    input  logic                          s_valid_i,
    output logic                          s_ready_o,
    input  logic [stream_pkg::WIDE_W-1:0] s_data_i,
    input  stream_pkg::opcode_e           s_op_i,
    input  logic                          s_last_i,
    output logic                          m_valid_o,
    input  logic                          m_ready_i,
    output logic [stream_pkg::WIDE_W-1:0] m_data_o,
    output logic                          m_last_o
);

    import stream_pkg::*;

    logic              valid_q;
    logic              last_q;
    logic [WIDE_W-1:0] data_q;
    logic [WIDE_W-1:0] xf_data;

    // ########################################################################
    // transform
    // ########################################################################

    always_comb begin
        xf_data = s_data_i;
        case (s_op_i)
            OP_PASS:   xf_data = s_data_i;
            OP_INVERT: xf_data = ~s_data_i;
            OP_LANE_REV: begin
                for (int k = 0; k < RATIO; k++) begin
                    xf_data[k*NARROW_W +: NARROW_W] =
                        s_data_i[(RATIO-1-k)*NARROW_W +: NARROW_W];
                end
            end
            OP_BYTE_SWAP: begin
                for (int k = 0; k < RATIO; k++) begin
                    for (int b = 0; b < LANE_BYTES; b++) begin
                        xf_data[(k*LANE_BYTES+b)*8 +: 8] =
                            s_data_i[(k*LANE_BYTES+LANE_BYTES-1-b)*8 +: 8];
                    end
                end
            end
            default:   xf_data = s_data_i;
        endcase
    end

    // ########################################################################
    // output register
    // ########################################################################

    assign s_ready_o = ~valid_q | m_ready_i;  // refill while draining.

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (s_ready_o) begin
            valid_q <= s_valid_i;
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_valid_i & s_ready_o) begin
            data_q <= xf_data;
            last_q <= s_last_i;
        end
    end

    assign m_valid_o = valid_q;
    assign m_data_o  = data_q;
    assign m_last_o  = last_q;

    a_hold_when_stalled : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (m_valid_o && !m_ready_i) |=> (m_valid_o && $stable(m_data_o) && $stable(m_last_o))
    ) else $error("executor output changed under back-pressure");

endmodule

`default_nettype wire

/* design/axis_downsizer.sv */
// wide-to-narrow stage; sends one held beat out as four words, lane 0 first.
`default_nettype none
`timescale 1ns/1ps

module axis_downsizer (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            s_valid_i,
    output logic                            s_ready_o,
    input  logic [stream_pkg::WIDE_W-1:0]   s_data_i,
    input  logic                            s_last_i,
    output logic                            m_valid_o,
    input  logic                            m_ready_i,
    output logic [stream_pkg::NARROW_W-1:0] m_data_o,
    output logic                            m_last_o
);

    import stream_pkg::*;

    logic [CNT_W-1:0]               cnt_q;
    logic                           cnt_done;
    logic                           busy_q;
    logic                           last_q;
    logic [RATIO-1:0][NARROW_W-1:0] beat_q;
    logic                           s_handshake;
    logic                           m_handshake;

    assign s_handshake = s_valid_i & s_ready_o;
    assign m_handshake = busy_q & m_ready_i;
    assign cnt_done    = (cnt_q == CNT_W'(RATIO - 1));

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            cnt_q <= '0;
        end else if (m_handshake) begin
            cnt_q <= cnt_done ? '0 : cnt_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q <= 1'b0;
        end else if (s_handshake) begin
            busy_q <= 1'b1;
        end else if (m_handshake & cnt_done) begin
            busy_q <= 1'b0;  // last lane gone.
        end
    end

    always_ff @(posedge clk_i) begin
        if (s_handshake) begin
            beat_q <= s_data_i;
            last_q <= s_last_i;
        end
    end

    assign s_ready_o = ~busy_q;
    assign m_valid_o = busy_q;
    assign m_data_o  = beat_q[cnt_q];
    assign m_last_o  = last_q & cnt_done;

    a_valid_held : assert property (
        @(posedge clk_i) disable iff (rst_i)
        (m_valid_o && !m_ready_i) |=> m_valid_o
    ) else $error("output valid dropped without a transfer");

endmodule

`default_nettype wire

/* design/stream_xform_top.sv */
// top of the packet transformer; chains decoder, upsizer, executor and downsizer.
`default_nettype none
`timescale 1ns/1ps

module stream_xform_top (
    input  logic                            clk_i,
    input  logic                            rst_i,
    input  logic                            s_valid_i,
    output logic                            s_ready_o,
    input  logic [stream_pkg::NARROW_W-1:0] s_data_i,
    input  logic                            s_last_i,
    output logic                            m_valid_o,
    input  logic                            m_ready_i,
    output logic [stream_pkg::NARROW_W-1:0] m_data_o,
    output logic                            m_last_o
);

    import stream_pkg::*;

    // ########################################################################
    // stage links
    // ########################################################################

    logic                dec_valid;
    logic                dec_ready;
    logic [NARROW_W-1:0] dec_data;
    opcode_e             dec_op;
    logic                dec_last;

    logic                up_valid;
    logic                up_ready;
    logic [WIDE_W-1:0]   up_data;
    opcode_e             up_op;
    logic                up_last;

    logic                ex_valid;
    logic                ex_ready;
    logic [WIDE_W-1:0]   ex_data;
    logic                ex_last;

    header_decoder u_decoder (
        .clk_i, .rst_i,
        .s_valid_i, .s_ready_o, .s_data_i, .s_last_i,
        .m_valid_o(dec_valid), .m_ready_i(dec_ready), .m_data_o(dec_data),
        .m_op_o(dec_op), .m_last_o(dec_last)
    );

    axis_upsizer u_upsizer (
        .clk_i, .rst_i,
        .s_valid_i(dec_valid), .s_ready_o(dec_ready), .s_data_i(dec_data),
        .s_op_i(dec_op), .s_last_i(dec_last),
        .m_valid_o(up_valid), .m_ready_i(up_ready), .m_data_o(up_data),
        .m_op_o(up_op), .m_last_o(up_last)
    );

    lane_executor u_executor (
        .clk_i, .rst_i,
        .s_valid_i(up_valid), .s_ready_o(up_ready), .s_data_i(up_data),
        .s_op_i(up_op), .s_last_i(up_last),
        .m_valid_o(ex_valid), .m_ready_i(ex_ready), .m_data_o(ex_data), .m_last_o(ex_last)
    );

    axis_downsizer u_downsizer (
        .clk_i, .rst_i,
        .s_valid_i(ex_valid), .s_ready_o(ex_ready), .s_data_i(ex_data), .s_last_i(ex_last),
        .m_valid_o, .m_ready_i, .m_data_o, .m_last_o
    );

endmodule

`default_nettype wire

/* dv/stream_xform_tb.sv */
// self-checking testbench for the stream transformer; built from files.f and run by run.sh.
`default_nettype none
`timescale 1ns/1ps

module stream_xform_tb;

    import stream_pkg::*;

    localparam int NUM_PKTS = 40;

    logic                clk_i = 1'b0;
    logic                rst_i;
    logic                s_valid_i;
    logic                s_ready_o;
    logic [NARROW_W-1:0] s_data_i;
    logic                s_last_i;
    logic                m_valid_o;
    logic                m_ready_i;
    logic [NARROW_W-1:0] m_data_o;
    logic                m_last_o;

    integer            seed = 69;
    int                cycles = 0;
    int                cycle_limit;
    logic [NARROW_W:0] in_q[$];   // {last, data} per input word.
    logic [NARROW_W:0] exp_q[$];  // {last, data} per output word.

    stream_xform_top UUT (
        .clk_i, .rst_i,
        .s_valid_i, .s_ready_o, .s_data_i, .s_last_i,
        .m_valid_o, .m_ready_i, .m_data_o, .m_last_o
    );

    always #2 clk_i = ~clk_i;

    // ########################################################################
    // reference model and check
    // ########################################################################

    function automatic logic [RATIO-1:0][NARROW_W-1:0] expected_group(
        input logic [RATIO-1:0][NARROW_W-1:0] words,
        input opcode_e                        op
    );
        logic [RATIO-1:0][NARROW_W-1:0] res;
        for (int k = 0; k < RATIO; k++) begin
            case (op)
                OP_INVERT:    res[k] = ~words[k];
                OP_LANE_REV:  res[k] = words[RATIO-1-k];  // lane 0 gets the last word.
                OP_BYTE_SWAP: res[k] = {words[k][7:0], words[k][15:8],
                                        words[k][23:16], words[k][31:24]};
                default:      res[k] = words[k];
            endcase
        end
        return res;
    endfunction

    task automatic check_value(input string what, input logic [NARROW_W-1:0] got,
                               input logic [NARROW_W-1:0] exp);
        if (got !== exp) begin
            $display("Error at %0t ns: %s mismatch, expected %h, got %h",
                     $time, what, exp, got);
            $display("Regression failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    // ########################################################################
    // stimulus
    // ########################################################################

    task automatic build_stimulus();
        logic [RATIO-1:0][NARROW_W-1:0] grp;
        logic [RATIO-1:0][NARROW_W-1:0] res;
        logic [NARROW_W-1:0]            header;
        logic                           last;
        opcode_e                        op;
        int                             groups;
        for (int p = 0; p < NUM_PKTS; p++) begin
            op = (p < 4) ? opcode_e'(p[1:0]) : opcode_e'(2'($random(seed)));
            groups = 1 + ({$random(seed)} % 3);
            header = $random(seed);  // upper bits are noise.
            header[1:0] = op;
            in_q.push_back({1'b0, header});
            for (int g = 0; g < groups; g++) begin
                for (int k = 0; k < RATIO; k++) begin
                    grp[k] = $random(seed);
                    last = (g == groups - 1) && (k == RATIO - 1);
                    in_q.push_back({last, grp[k]});
                end
                res = expected_group(grp, op);
                for (int k = 0; k < RATIO; k++) begin
                    last = (g == groups - 1) && (k == RATIO - 1);
                    exp_q.push_back({last, res[k]});
                end
            end
        end
        cycle_limit = in_q.size() * 10 + 200;
    endtask

    task automatic send_word(input logic [NARROW_W:0] word);
        logic taken;
        s_valid_i = 1'b1;
        s_last_i  = word[NARROW_W];
        s_data_i  = word[NARROW_W-1:0];
        taken     = 1'b0;
        while (!taken) begin
            @(negedge clk_i);
            taken = s_ready_o;  // transfer lands on the next rising edge.
            @(posedge clk_i);
            #1;
        end
        s_valid_i = 1'b0;
    endtask

    // random stalls on the output side.
    always @(posedge clk_i) begin
        #1;
        m_ready_i = (({$random(seed)} % 4) != 0) && !rst_i;
    end

    // ########################################################################
    // monitor and timeout
    // ########################################################################

    always @(negedge clk_i) begin : monitor
        logic [NARROW_W:0] exp_word;
        if (!rst_i && m_valid_o && m_ready_i) begin
            if (exp_q.size() == 0) begin
                $display("Output word %h at %0t ns arrived with nothing left to expect",
                         m_data_o, $time);
                $display("Regression failed");
                $fatal(1, "extra output word");
            end else begin
                exp_word = exp_q.pop_front();
                check_value("m_data_o", m_data_o, exp_word[NARROW_W-1:0]);
                check_value("m_last_o", NARROW_W'(m_last_o), NARROW_W'(exp_word[NARROW_W]));
            end
        end
    end

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            $display("Timeout after %0d cycles with %0d output words still missing",
                     cycles, exp_q.size());
            $display("Regression failed");
            $fatal(1, "timeout");
        end
    end

    initial begin
        rst_i     = 1'b1;
        s_valid_i = 1'b0;
        s_data_i  = '0;
        s_last_i  = 1'b0;
        m_ready_i = 1'b0;
        build_stimulus();
        repeat (8) @(posedge clk_i);
        #1;
        rst_i = 1'b0;
        @(negedge clk_i);
        check_value("m_valid_o after reset", NARROW_W'(m_valid_o), '0);
        @(posedge clk_i);
        #1;
        while (in_q.size() != 0) begin
            send_word(in_q.pop_front());
        end
        while (exp_q.size() != 0) begin
            @(posedge clk_i);
        end
        repeat (20) @(posedge clk_i);  // catch stray words.
        $display("Regression passed");
        $finish;
    end

endmodule

`default_nettype wire

/* files.f */
design/stream_pkg.sv
design/header_decoder.sv
design/axis_upsizer.sv
design/lane_executor.sv
design/axis_downsizer.sv
design/stream_xform_top.sv
dv/stream_xform_tb.sv

/* run.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f files.f \
    --top-module stream_xform_tb -o stream_xform_sim
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/stream_xform_sim 2>&1)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1
